// File: compile.f
src/shmem_pkg.sv
src/mem_bank.sv
src/core_arbiter.sv
src/shared_mem.sv
tests/mem_checker.sv
tests/tb_shared_mem.sv

// File: run_sim.sh
#!/bin/sh
# build and run the shared memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

PASS_TEXT="Simulation completed successfully"

verilator --binary --timing -Wno-fatal \
	-f compile.f \
	--top-module tb_shared_mem \
	-o sim_shared_mem
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/sim_shared_mem)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q -x "$PASS_TEXT"; then
	exit 0
else
	echo "pass message not found in simulation output"
	exit 1
fi

// File: src/core_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module core_arbiter
#(
	parameter  int NUM_CORES = 4,
	localparam int CORE_ID_W = $clog2(NUM_CORES)
)
(
	input  wire                   clk,
	input  wire                   reset,
	input  wire [2*NUM_CORES-1:0] req,
	output logic                  grant_valid,
	output logic [CORE_ID_W-1:0]  grant_core,
	output logic [NUM_CORES-1:0]  ready,
	output logic [CORE_ID_W-1:0]  resp_core,
	output logic                  resp_read
);

	import shmem_pkg::*;

	req_t core_req [NUM_CORES];
	logic resp_valid;   // a grant was made in the previous cycle
	logic grant_read;

	for (genvar c = 0; c < NUM_CORES; c++)
	begin : g_req
		assign core_req[c] = req_t'(req[2*c +: 2]);
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// round-robin search
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// resp_core keeps the last granted core even through idle cycles,
	// so it is also the reference point of the search

	always_comb
	begin
		int idx;
		logic skip_last;

		grant_valid = 1'b0;
		grant_core  = '0;
		idx         = 0;
		for (int step = 1; step <= NUM_CORES; step++)
		begin
			idx       = (int'(resp_core) + step) % NUM_CORES;
			skip_last = resp_valid && (idx == int'(resp_core)); // its ready is still high
			if (!grant_valid && (core_req[idx] != REQ_IDLE) && !skip_last)
			begin
				grant_valid = 1'b1;
				grant_core  = CORE_ID_W'(idx);
			end
		end
	end

	assign grant_read = req_is_read(core_req[grant_core]);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// response state
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			resp_valid <= 1'b0;
			resp_read  <= 1'b0;
			resp_core  <= CORE_ID_W'(NUM_CORES - 1); // first search then begins at core 0
		end
		else
		begin
			resp_valid <= grant_valid;
			resp_read  <= grant_valid && grant_read;
			if (grant_valid)
			begin
				resp_core <= grant_core;
			end
		end
	end

	// one ready pulse for the core that was granted last cycle
	always_comb
	begin
		ready = '0;
		if (resp_valid)
		begin
			ready[resp_core] = 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: src/mem_bank.sv
`timescale 1ns/100ps
`default_nettype none

module mem_bank
(
	input  wire                   clk,
	input  wire shmem_pkg::word_addr_t word_addr,
	input  wire shmem_pkg::data_t wr_data,
	input  wire                   rd_en,
	input  wire                   wr_en,
	output shmem_pkg::data_t      rd_data
);

	import shmem_pkg::*;

	localparam int DEPTH = 2 ** WORD_ADDR_W;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// storage
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	data_t mem [DEPTH];

	// write lands at the edge where wr_en is seen
	always_ff @(posedge clk)
	begin
		if (wr_en)
		begin
			mem[word_addr] <= wr_data;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// registered read port
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk)
	begin
		if (rd_en)
		begin
			rd_data <= mem[word_addr]; // holds its value between reads
		end
	end

endmodule

`default_nettype wire

// File: src/shared_mem.sv
`timescale 1ns/100ps
`default_nettype none

module shared_mem
#(
	parameter  int NUM_CORES = 4,
	localparam int CORE_ID_W = $clog2(NUM_CORES)
)
(
	input  wire                                   clk,
	input  wire                                   reset,
	input  wire [2*NUM_CORES-1:0]                 req,
	input  wire [shmem_pkg::ADDR_W*NUM_CORES-1:0] addr,
	input  wire [shmem_pkg::WORD_W*NUM_CORES-1:0] wr_data,
	output wire [shmem_pkg::WORD_W*NUM_CORES-1:0] rd_data,
	output wire [NUM_CORES-1:0]                   ready
);

	import shmem_pkg::*;

	// per-core views of the flattened buses
	logic [1:0] core_req     [NUM_CORES];
	addr_t      core_addr    [NUM_CORES];
	data_t      core_wr_data [NUM_CORES];

	// access chosen this cycle
	logic                 grant_valid;
	logic [CORE_ID_W-1:0] grant_core;
	logic [1:0]           sel_req;
	addr_t                sel_addr;
	data_t                sel_wr_data;
	bank_id_t             sel_bank;
	word_addr_t           sel_word;
	logic                 sel_read;
	logic                 sel_write;

	// answer to the access of the previous cycle
	logic [CORE_ID_W-1:0] resp_core;
	logic                 resp_read;
	bank_id_t             resp_bank;
	data_t                resp_data;

	logic [BANK_COUNT-1:0] bank_rd_en;
	logic [BANK_COUNT-1:0] bank_wr_en;
	data_t                 bank_rd_data [BANK_COUNT];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// core side
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	for (genvar c = 0; c < NUM_CORES; c++)
	begin : g_core
		assign core_req[c]     = req[2*c +: 2];
		assign core_addr[c]    = addr[ADDR_W*c +: ADDR_W];
		assign core_wr_data[c] = wr_data[WORD_W*c +: WORD_W];

		// only the responding core sees read data and only on a read
		assign rd_data[WORD_W*c +: WORD_W] =
			(resp_read && (resp_core == CORE_ID_W'(c))) ? resp_data : '0;
	end

	core_arbiter
	#(
		.NUM_CORES(NUM_CORES)
	)
	u_arbiter
	(
		.clk(clk),
		.reset(reset),
		.req(req),
		.grant_valid(grant_valid),
		.grant_core(grant_core),
		.ready(ready),
		.resp_core(resp_core),
		.resp_read(resp_read)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// routing of the granted access
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign sel_req     = core_req[grant_core];
	assign sel_addr    = core_addr[grant_core];
	assign sel_wr_data = core_wr_data[grant_core];

	assign {sel_bank, sel_word} = sel_addr;

	assign sel_read  = grant_valid && req_is_read(sel_req);
	assign sel_write = grant_valid && req_is_write(sel_req);

	// word address and data are shared, the enables pick the bank
	for (genvar b = 0; b < BANK_COUNT; b++)
	begin : g_bank
		assign bank_rd_en[b] = sel_read && (sel_bank == BANK_ID_W'(b));
		assign bank_wr_en[b] = sel_write && (sel_bank == BANK_ID_W'(b));

		mem_bank u_bank
		(
			.clk(clk),
			.word_addr(sel_word),
			.wr_data(sel_wr_data),
			.rd_en(bank_rd_en[b]),
			.wr_en(bank_wr_en[b]),
			.rd_data(bank_rd_data[b])
		);
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// read return
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// bank number follows the bank read data by one cycle
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			resp_bank <= '0;
		end
		else if (grant_valid)
		begin
			resp_bank <= sel_bank;
		end
	end

	assign resp_data = bank_rd_data[resp_bank];

endmodule

`default_nettype wire

// File: src/shmem_pkg.sv
`default_nettype none

package shmem_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// memory geometry
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int WORD_W      = 16;
	localparam int BANK_ID_W   = 2;
	localparam int BANK_COUNT  = 2 ** BANK_ID_W;
	localparam int WORD_ADDR_W = 6;
	localparam int ADDR_W      = BANK_ID_W + WORD_ADDR_W; // bank number sits above the word

	typedef logic [WORD_W-1:0]      data_t;
	typedef logic [ADDR_W-1:0]      addr_t;
	typedef logic [BANK_ID_W-1:0]   bank_id_t;
	typedef logic [WORD_ADDR_W-1:0] word_addr_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// core request codes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef enum logic [1:0] {
		REQ_IDLE  = 2'b00,
		REQ_READ  = 2'b01,
		REQ_WRITE = 2'b10
	} req_t;

	function automatic logic req_is_read(input logic [1:0] code);
		return code == REQ_READ;
	endfunction

	// the unused code 11 behaves like a write
	function automatic logic req_is_write(input logic [1:0] code);
		return code[1];
	endfunction

endpackage

`default_nettype wire

// File: tests/mem_checker.sv
`timescale 1ns/100ps
`default_nettype none

module mem_checker
#(
	parameter  int NUM_CORES = 4,
	localparam int CORE_ID_W = $clog2(NUM_CORES)
)
(
	input wire                                   clk,
	input wire                                   reset,
	input wire [2*NUM_CORES-1:0]                 req,
	input wire [shmem_pkg::ADDR_W*NUM_CORES-1:0] addr,
	input wire [shmem_pkg::WORD_W*NUM_CORES-1:0] wr_data,
	input wire [shmem_pkg::WORD_W*NUM_CORES-1:0] rd_data,
	input wire [NUM_CORES-1:0]                   ready
);

	import shmem_pkg::*;

	data_t              model_mem [2**ADDR_W];
	logic [2**ADDR_W-1:0] model_valid;

	logic [NUM_CORES-1:0] pending;
	logic [NUM_CORES-1:0] served;
	logic [1:0]           pend_op   [NUM_CORES];
	addr_t                pend_addr [NUM_CORES];
	data_t                pend_wr   [NUM_CORES];

	string                          test_name;
	int                             exp_count;
	logic [NUM_CORES*CORE_ID_W-1:0] exp_order;
	logic [NUM_CORES*WORD_W-1:0]    exp_rd;
	int                             cyc;
	int                             served_count;
	int                             test_errors;
	int                             error_count;
	int                             tests_done;

	initial
	begin
		model_valid  = '0;
		pending      = '0;
		served       = '0;
		exp_count    = 0;
		cyc          = 0;
		served_count = 0;
		test_errors  = 0;
		error_count  = 0;
		tests_done   = 0;
		test_name    = "none";
	end

	task automatic count_error();
		error_count++;
		test_errors++;
	endtask

	task automatic begin_batch(input string name, input int count,
		input logic [NUM_CORES*CORE_ID_W-1:0] order, input logic [NUM_CORES*WORD_W-1:0] exp_values);
		test_name    = name;
		exp_count    = count;
		exp_order    = order;
		exp_rd       = exp_values;
		cyc          = -1; // the first negedge of the batch has no ready yet
		served       = '0;
		served_count = 0;
		test_errors  = 0;
	endtask

	task automatic end_batch();
		if (served_count != exp_count)
		begin
			$display("test %s served %0d cores but %0d were expected", test_name,
				served_count, exp_count);
			count_error();
		end
		if (test_errors == 0)
			$display("test %-18s ok", test_name);
		else
			$display("test %-18s %0d errors", test_name, test_errors);
		tests_done++;
	endtask

	task automatic report_totals();
		$display("tests run %0d, failed checks %0d", tests_done, error_count);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// sampling in mid cycle
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always @(negedge clk)
	begin
		logic [NUM_CORES-1:0]        exp_ready;
		logic [NUM_CORES*WORD_W-1:0] exp_data;
		int                          core;

		exp_ready = '0;
		exp_data  = '0;
		core      = -1;
		if (reset)
		begin
			if (ready != '0)
			begin
				$display("FAILED %0t ready expected %b got %b", $time, exp_ready, ready);
				count_error();
			end
		end
		else
		begin
			cyc++;
			if (cyc >= 1 && cyc <= exp_count)
			begin
				core = int'(exp_order[CORE_ID_W*(cyc-1) +: CORE_ID_W]);
				exp_ready[core] = 1'b1; // one cycle per served core, in order
			end
			if ((ready & ~pending) != '0)
			begin
				$display("at %0t ready %b was raised for a core with no pending request",
					$time, ready);
				count_error();
			end
			else if (ready != exp_ready)
			begin
				$display("FAILED %0t ready expected %b got %b", $time, exp_ready, ready);
				count_error();
			end
			if (core >= 0 && ready[core] && pending[core])
			begin
				if (pend_op[core] == 2'b01)
				begin
					if (!model_valid[pend_addr[core]])
					begin
						$display("test %s reads address %h before any write", test_name,
							pend_addr[core]);
						count_error();
					end
					else if (exp_rd[WORD_W*core +: WORD_W] != model_mem[pend_addr[core]])
					begin
						$display("pattern of test %s expects %h but the model holds %h",
							test_name, exp_rd[WORD_W*core +: WORD_W],
							model_mem[pend_addr[core]]);
						count_error();
					end
					exp_data[WORD_W*core +: WORD_W] = model_mem[pend_addr[core]];
				end
				else
				begin
					model_mem[pend_addr[core]]   = pend_wr[core]; // codes 10 and 11
					model_valid[pend_addr[core]] = 1'b1;
				end
				pending[core] = 1'b0;
				served[core]  = 1'b1;
				served_count++;
			end
			for (int c = 0; c < NUM_CORES; c++)
			begin
				if (rd_data[WORD_W*c +: WORD_W] != exp_data[WORD_W*c +: WORD_W])
				begin
					$display("FAILED %0t rd_data[%0d] expected %h got %h", $time, c,
						exp_data[WORD_W*c +: WORD_W], rd_data[WORD_W*c +: WORD_W]);
					count_error();
				end
				if (!pending[c] && !served[c] && req[2*c +: 2] != 2'b00)
				begin
					pending[c]   = 1'b1;
					pend_op[c]   = req[2*c +: 2];
					pend_addr[c] = addr[ADDR_W*c +: ADDR_W];
					pend_wr[c]   = wr_data[WORD_W*c +: WORD_W];
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: tests/shared_mem_patterns.txt
# one batch per line: name, then for cores 0..3: op addr wr_data read_expect (hex)
# op 0 idle, 1 read, 2 write, 3 write; then served count and service order (decimal)

# after reset the search starts at core 0
reset_first   0 00 0000 0000 2 05 1111 0000 2 06 2222 0000 0 00 0000 0000 2 1 2 0 0
single_wr     2 10 abcd 0000 0 00 0000 0000 0 00 0000 0000 0 00 0000 0000 1 0 0 0 0
single_rd     1 10 0000 abcd 0 00 0000 0000 0 00 0000 0000 0 00 0000 0000 1 0 0 0 0
single_rd2    0 00 0000 0000 0 00 0000 0000 1 05 0000 1111 0 00 0000 0000 1 2 0 0 0

# all cores at once, round robin from one past the last served core
all_four_wr   2 00 a000 0000 2 40 b001 0000 2 80 c002 0000 2 c0 d003 0000 4 3 0 1 2
all_four_rd   1 c0 0000 d003 1 80 0000 c002 1 40 0000 b001 1 00 0000 a000 4 3 0 1 2

# lone requester holds through its ready cycle
lone_hold_wr  0 00 0000 0000 0 00 0000 0000 2 81 0f0f 0000 0 00 0000 0000 1 2 0 0 0
lone_hold_rd  0 00 0000 0000 0 00 0000 0000 1 81 0000 0f0f 0 00 0000 0000 1 2 0 0 0

# same address written twice, the later served core wins
same_addr_a   2 22 1234 0000 0 00 0000 0000 0 00 0000 0000 2 22 5678 0000 2 3 0 0 0
same_addr_rd  0 00 0000 0000 1 22 0000 1234 0 00 0000 0000 0 00 0000 0000 1 1 0 0 0
same_addr_b   0 00 0000 0000 2 33 aaaa 0000 2 33 bbbb 0000 0 00 0000 0000 2 2 1 0 0
same_addr_rd2 1 22 0000 1234 0 00 0000 0000 0 00 0000 0000 1 33 0000 aaaa 2 3 0 0 0

# mixed reads and writes across banks
mix_a         2 7f 7e7e 0000 1 00 0000 a000 2 ff ffff 0000 1 c0 0000 d003 4 1 2 3 0
mix_rd        1 ff 0000 ffff 1 7f 0000 7e7e 0 00 0000 0000 0 00 0000 0000 2 1 0 0 0
code_11_wr    0 00 0000 0000 0 00 0000 0000 0 00 0000 0000 3 45 4545 0000 1 3 0 0 0
code_11_rd    0 00 0000 0000 1 45 0000 4545 1 05 0000 1111 0 00 0000 0000 2 1 2 0 0
wr_then_rd    1 12 0000 9999 0 00 0000 0000 0 00 0000 0000 2 12 9999 0000 2 3 0 0 0
pair_wr       0 00 0000 0000 2 3e 3e3e 0000 0 00 0000 0000 2 be bebe 0000 2 1 3 0 0
pair_rd       1 3e 0000 3e3e 0 00 0000 0000 1 be 0000 bebe 0 00 0000 0000 2 0 2 0 0
all_four_wr2  2 01 0101 0000 2 41 4141 0000 2 82 8282 0000 2 c1 c1c1 0000 4 3 0 1 2
all_four_rd2  1 c1 0000 c1c1 1 82 0000 8282 1 41 0000 4141 1 01 0000 0101 4 3 0 1 2
lone_c3       0 00 0000 0000 0 00 0000 0000 0 00 0000 0000 1 12 0000 9999 1 3 0 0 0
lone_c0       1 7f 0000 7e7e 0 00 0000 0000 0 00 0000 0000 0 00 0000 0000 1 0 0 0 0
three_wr      0 00 0000 0000 2 50 5050 0000 2 90 9090 0000 2 d0 d0d0 0000 3 1 2 3 0
three_rd      1 50 0000 5050 1 90 0000 9090 1 d0 0000 d0d0 0 00 0000 0000 3 0 1 2 0

# read served before a write to the same word sees the old value
rd_before_wr  1 33 0000 aaaa 2 33 cccc 0000 0 00 0000 0000 0 00 0000 0000 2 0 1 0 0
rd_after_wr   0 00 0000 0000 0 00 0000 0000 1 33 0000 cccc 0 00 0000 0000 1 2 0 0 0

// File: tests/tb_shared_mem.sv
`timescale 1ns/100ps
`default_nettype none

module tb_shared_mem;

	import shmem_pkg::*;

	localparam int NUM_CORES   = 4;
	localparam int CORE_ID_W   = $clog2(NUM_CORES);
	localparam int MAX_BATCHES = 64;

	logic                        clk;
	logic                        reset;
	logic [2*NUM_CORES-1:0]      req;
	logic [ADDR_W*NUM_CORES-1:0] addr;
	logic [WORD_W*NUM_CORES-1:0] wr_data;
	wire  [WORD_W*NUM_CORES-1:0] rd_data;
	wire  [NUM_CORES-1:0]        ready;

	// one entry per pattern line
	string      batch_name  [MAX_BATCHES];
	logic [1:0] batch_op    [MAX_BATCHES][NUM_CORES];
	addr_t      batch_addr  [MAX_BATCHES][NUM_CORES];
	data_t      batch_wr    [MAX_BATCHES][NUM_CORES];
	data_t      batch_exp   [MAX_BATCHES][NUM_CORES];
	int         batch_count [MAX_BATCHES];
	int         batch_order [MAX_BATCHES][NUM_CORES];
	int         num_batches;
	int         cycle_count;
	int         cycle_limit;

	shared_mem
	#(
		.NUM_CORES(NUM_CORES)
	)
	DUT
	(
		.clk(clk),
		.reset(reset),
		.req(req),
		.addr(addr),
		.wr_data(wr_data),
		.rd_data(rd_data),
		.ready(ready)
	);

	mem_checker
	#(
		.NUM_CORES(NUM_CORES)
	)
	mem_check
	(
		.clk(clk),
		.reset(reset),
		.req(req),
		.addr(addr),
		.wr_data(wr_data),
		.rd_data(rd_data),
		.ready(ready)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// pattern file
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic load_patterns(output logic loaded);
		int    fd;
		int    n;
		string line;
		string name;
		int    f [21];

		loaded      = 1'b0;
		num_batches = 0;
		fd = $fopen("tests/shared_mem_patterns.txt", "r");
		if (fd != 0)
		begin
			loaded = 1'b1;
			while (!$feof(fd) && num_batches < MAX_BATCHES)
			begin
				if ($fgets(line, fd) == 0)
					continue;
				if (line.len() < 2 || line.getc(0) == "#")
					continue; // blank lines and column notes
				n = $sscanf(line,
					"%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %d %d %d %d %d",
					name, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
					f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18],
					f[19], f[20]);
				if (n != 22)
					continue;
				batch_name[num_batches]  = name;
				batch_count[num_batches] = f[16];
				for (int c = 0; c < NUM_CORES; c++)
				begin
					batch_op[num_batches][c]    = 2'(f[4*c]);
					batch_addr[num_batches][c]  = addr_t'(f[4*c+1]);
					batch_wr[num_batches][c]    = data_t'(f[4*c+2]);
					batch_exp[num_batches][c]   = data_t'(f[4*c+3]);
					batch_order[num_batches][c] = f[17+c];
				end
				num_batches++;
			end
			$fclose(fd);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// request driving
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// called just after a rising edge, returns at the same point of a later cycle
	task automatic run_batch(input int b);
		logic [NUM_CORES-1:0]           active;
		logic [NUM_CORES-1:0]           drop;
		logic [NUM_CORES*CORE_ID_W-1:0] order_flat;
		logic [NUM_CORES*WORD_W-1:0]    exp_flat;

		active = '0;
		drop   = '0;
		for (int c = 0; c < NUM_CORES; c++)
		begin
			order_flat[CORE_ID_W*c +: CORE_ID_W] = CORE_ID_W'(batch_order[b][c]);
			exp_flat[WORD_W*c +: WORD_W]         = batch_exp[b][c];
			req[2*c +: 2]                        = batch_op[b][c];
			addr[ADDR_W*c +: ADDR_W]             = batch_addr[b][c];
			wr_data[WORD_W*c +: WORD_W]          = batch_wr[b][c];
			active[c]                            = batch_op[b][c] != 2'b00;
		end
		mem_check.begin_batch(batch_name[b], batch_count[b], order_flat, exp_flat);
		while (active != '0)
		begin
			@(posedge clk);
			#5;
			for (int c = 0; c < NUM_CORES; c++)
			begin
				if (drop[c])
				begin
					req[2*c +: 2] = 2'b00; // request held through the ready cycle
					active[c]     = 1'b0;
					drop[c]       = 1'b0;
				end
				else if (active[c] && ready[c])
				begin
					drop[c] = 1'b1;
				end
			end
		end
		mem_check.end_batch();
	endtask

	initial
	begin
		int   idle;
		logic loaded;

		req     = '0;
		addr    = '0;
		wr_data = '0;
		reset   = 1'b1;
		void'($urandom(92955));
		load_patterns(loaded);
		cycle_limit = 4 * num_batches * NUM_CORES + 100;
		repeat (10) @(posedge clk);
		#5;
		reset = 1'b0;
		if (!loaded || num_batches == 0)
		begin
			$display("pattern file tests/shared_mem_patterns.txt missing or empty");
			$display("Simulation failed");
		end
		else
		begin
			for (int b = 0; b < num_batches; b++)
			begin
				run_batch(b);
				idle = int'($urandom_range(3));
				if (idle > 0)
				begin
					repeat (idle) @(posedge clk);
					#5;
				end
			end
			mem_check.report_totals();
			if (mem_check.error_count == 0)
				$display("Simulation completed successfully");
			else
				$display("Simulation failed");
		end
		$finish;
	end

	initial
	begin
		cycle_count = 0;
		while (cycle_limit == 0 || cycle_count <= cycle_limit)
		begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout after %0d cycles, some request was never answered", cycle_count);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire
